// ==== flist.f ====
+incdir+test
src/mipsPkg.sv
src/decodeExecuteIf.sv
src/fetchStage.sv
src/decodeStage.sv
src/decodeExecuteReg.sv
src/executeStage.sv
src/memStage.sv
src/mipsCore.sv
test/tbCore.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tbCore -Mdir obj_dir -f flist.f

# A fatal stop exits nonzero, the log is searched afterwards
./obj_dir/VtbCore > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL: no result line in sim.log"
  exit 1
fi
echo "PASS"

// ==== src/decodeExecuteIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction bundle between decode and execute
interface decodeExecuteIf;

  mipsPkg::ctrlS ctrl;
  logic [31:0]   readData1;
  logic [31:0]   readData2;
  logic [4:0]    readReg1;
  logic [4:0]    readReg2;
  logic [31:0]   immExt;
  logic [31:0]   pcPlus4;
  logic [4:0]    writeReg;
  logic [4:0]    shftAmt;
  logic          valid;

  modport source (
    output ctrl, readData1, readData2, readReg1, readReg2,
    output immExt, pcPlus4, writeReg, shftAmt, valid
  );

  modport sink (
    input ctrl, readData1, readData2, readReg1, readReg2,
    input immExt, pcPlus4, writeReg, shftAmt, valid
  );

endinterface

`default_nettype wire

// ==== src/decodeExecuteReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteReg (
  input  logic           Clk,
  input  logic           arstN,
  input  logic           stall,
  input  logic           redirect,
  decodeExecuteIf.sink   deIn,
  decodeExecuteIf.source deOut
);

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      deOut.ctrl      <= '0;
      deOut.readData1 <= 32'd0;
      deOut.readData2 <= 32'd0;
      deOut.readReg1  <= 5'd0;
      deOut.readReg2  <= 5'd0;
      deOut.immExt    <= 32'd0;
      deOut.pcPlus4   <= 32'd0;
      deOut.writeReg  <= 5'd0;
      deOut.shftAmt   <= 5'd0;
      deOut.valid     <= 1'b0;
    end else if (!stall) begin
      deOut.readData1 <= deIn.readData1;
      deOut.readData2 <= deIn.readData2;
      deOut.readReg1  <= deIn.readReg1;
      deOut.readReg2  <= deIn.readReg2;
      deOut.immExt    <= deIn.immExt;
      deOut.pcPlus4   <= deIn.pcPlus4;
      deOut.writeReg  <= deIn.writeReg;
      deOut.shftAmt   <= deIn.shftAmt;
      // Wrong-path instruction becomes a bubble
      if (redirect) begin
        deOut.ctrl  <= '0;
        deOut.valid <= 1'b0;
      end else begin
        deOut.ctrl  <= deIn.ctrl;
        deOut.valid <= deIn.valid;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic           Clk,
  input  logic           arstN,
  input  mipsPkg::instrU instrD,
  input  logic [31:0]    pcPlus4D,
  input  logic           validD,
  input  logic           wbEn,
  input  logic [4:0]     wbReg,
  input  logic [31:0]    wbData,
  decodeExecuteIf.source deOut
);

  mipsPkg::ctrlS ctrl;
  logic [31:0]   regFile [32];
  logic [4:0]    rs;
  logic [4:0]    rt;

  assign rs = instrD.iType.rs;
  assign rt = instrD.iType.rt;

  //////////////////////////////
  // Control decoder
  //////////////////////////////
  always_comb begin
    ctrl = '0;
    case (instrD.rType.opcode)
      mipsPkg::OP_RTYPE: begin
        ctrl.regWrite = 1'b1;
        case (instrD.rType.funct)
          mipsPkg::FN_ADDU: ctrl.aluOp = mipsPkg::ALU_ADD;
          mipsPkg::FN_SUBU: ctrl.aluOp = mipsPkg::ALU_SUB;
          mipsPkg::FN_AND:  ctrl.aluOp = mipsPkg::ALU_AND;
          mipsPkg::FN_OR:   ctrl.aluOp = mipsPkg::ALU_OR;
          mipsPkg::FN_XOR:  ctrl.aluOp = mipsPkg::ALU_XOR;
          mipsPkg::FN_SLT:  ctrl.aluOp = mipsPkg::ALU_SLT;
          mipsPkg::FN_SLL:  ctrl.aluOp = mipsPkg::ALU_SLL;
          mipsPkg::FN_SRL:  ctrl.aluOp = mipsPkg::ALU_SRL;
          // Unknown function behaves as a nop
          default:          ctrl.regWrite = 1'b0;
        endcase
      end
      mipsPkg::OP_ADDIU: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::OP_ANDI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.aluOp    = mipsPkg::ALU_AND;
      end
      mipsPkg::OP_ORI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.aluOp    = mipsPkg::ALU_OR;
      end
      mipsPkg::OP_LUI: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.aluOp    = mipsPkg::ALU_LUI;
      end
      mipsPkg::OP_LW: begin
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::OP_SW: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      mipsPkg::OP_BEQ:  ctrl.branchType = mipsPkg::BR_BEQ;
      mipsPkg::OP_BNE:  ctrl.branchType = mipsPkg::BR_BNE;
      mipsPkg::OP_JAL: begin
        ctrl.branchType = mipsPkg::BR_JAL;
        ctrl.regWrite   = 1'b1;
      end
      mipsPkg::OP_DISP: ctrl.display = 1'b1;
      default:          ctrl = '0;
    endcase
  end

  //////////////////////////////
  // Register file
  //////////////////////////////
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regFile[i] <= 32'd0;
      end
    end else if (wbEn && wbReg != 5'd0) begin
      regFile[wbReg] <= wbData;
    end
  end

  // Write-first bypass so a retiring result is seen in the same cycle
  always_comb begin
    if (rs == 5'd0) begin
      deOut.readData1 = 32'd0;
    end else if (wbEn && wbReg == rs) begin
      deOut.readData1 = wbData;
    end else begin
      deOut.readData1 = regFile[rs];
    end
    if (rt == 5'd0) begin
      deOut.readData2 = 32'd0;
    end else if (wbEn && wbReg == rt) begin
      deOut.readData2 = wbData;
    end else begin
      deOut.readData2 = regFile[rt];
    end
  end

  assign deOut.ctrl     = ctrl;
  assign deOut.readReg1 = rs;
  assign deOut.readReg2 = rt;
  assign deOut.immExt   = ctrl.zeroExt ? {16'd0, instrD.iType.imm16}
                                       : {{16{instrD.iType.imm16[15]}}, instrD.iType.imm16};
  assign deOut.pcPlus4  = pcPlus4D;
  assign deOut.shftAmt  = instrD.rType.shamt;
  assign deOut.valid    = validD;

  // JAL links into r31
  assign deOut.writeReg = (ctrl.branchType == mipsPkg::BR_JAL) ? 5'd31 :
                          (instrD.rType.opcode == mipsPkg::OP_RTYPE) ? instrD.rType.rd
                                                                     : rt;

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic          Clk,
  input  logic          arstN,
  input  logic          stall,
  decodeExecuteIf.sink  exIn,
  input  logic          wbEn,
  input  logic [4:0]    wbReg,
  input  logic [31:0]   wbData,
  output logic          redirect,
  output logic [31:0]   redirectPc,
  output mipsPkg::ctrlS memCtrl,
  output logic [31:0]   aluResult,
  output logic [31:0]   storeData,
  output logic [4:0]    destReg,
  output logic          memValid
);

  logic        fwdA;
  logic        fwdB;
  logic [31:0] srcA;
  logic [31:0] rtVal;
  logic [31:0] srcB;
  logic [31:0] aluOut;
  logic [31:0] result;
  logic        taken;

  // Forward from the instruction retiring this cycle
  assign fwdA  = wbEn && (wbReg != 5'd0) && (wbReg == exIn.readReg1);
  assign fwdB  = wbEn && (wbReg != 5'd0) && (wbReg == exIn.readReg2);
  assign srcA  = fwdA ? wbData : exIn.readData1;
  assign rtVal = fwdB ? wbData : exIn.readData2;
  assign srcB  = exIn.ctrl.aluSrc ? exIn.immExt : rtVal;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (exIn.ctrl.aluOp)
      mipsPkg::ALU_ADD: aluOut = srcA + srcB;
      mipsPkg::ALU_SUB: aluOut = srcA - srcB;
      mipsPkg::ALU_AND: aluOut = srcA & srcB;
      mipsPkg::ALU_OR:  aluOut = srcA | srcB;
      mipsPkg::ALU_XOR: aluOut = srcA ^ srcB;
      mipsPkg::ALU_SLT: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
      mipsPkg::ALU_SLL: aluOut = srcB << exIn.shftAmt;
      mipsPkg::ALU_SRL: aluOut = srcB >> exIn.shftAmt;
      mipsPkg::ALU_LUI: aluOut = {srcB[15:0], 16'd0};
      default:          aluOut = 32'd0;
    endcase
  end

  // Branch resolution
  always_comb begin
    case (exIn.ctrl.branchType)
      mipsPkg::BR_BEQ: taken = (srcA == rtVal);
      mipsPkg::BR_BNE: taken = (srcA != rtVal);
      mipsPkg::BR_JAL: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  // Operands may be stale while memory stalls
  assign redirect   = exIn.valid && taken && !stall;
  assign redirectPc = exIn.pcPlus4 + {exIn.immExt[29:0], 2'b00};
  assign result     = (exIn.ctrl.branchType == mipsPkg::BR_JAL) ? exIn.pcPlus4 : aluOut;

  //////////////////////////////
  // Execute/memory register
  //////////////////////////////
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      memCtrl  <= '0;
      memValid <= 1'b0;
    end else if (!stall) begin
      memCtrl  <= exIn.ctrl;
      memValid <= exIn.valid;
    end
  end

  always_ff @(posedge Clk) begin
    if (!stall) begin
      aluResult <= result;
      storeData <= rtVal;
      destReg   <= exIn.writeReg;
    end
  end

endmodule

`default_nettype wire

// ==== src/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic          Clk,
  input  logic          arstN,
  input  logic          stall,
  input  logic          redirect,
  input  logic [31:0]   redirectPc,
  output logic [31:0]   imemAddr,
  input  logic [31:0]   imemData,
  output mipsPkg::instrU instrD,
  output logic [31:0]   pcPlus4D,
  output logic          validD
);

  logic [31:0] pc;

  assign imemAddr = pc;

  // PC and valid bit of the fetch/decode register
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      pc     <= resetPc;
      validD <= 1'b0;
    end else if (!stall) begin
      if (redirect) begin
        pc     <= redirectPc;
        validD <= 1'b0;
      end else begin
        pc     <= pc + 32'd4;
        validD <= 1'b1;
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (!stall) begin
      instrD   <= imemData;
      pcPlus4D <= pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

// ==== src/memStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStage (
  input  logic          Clk,
  input  logic          arstN,
  input  mipsPkg::ctrlS memCtrl,
  input  logic [31:0]   aluResult,
  input  logic [31:0]   storeData,
  input  logic [4:0]    destReg,
  input  logic          memValid,
  output logic          stall,
  output logic          wbEn,
  output logic [4:0]    wbReg,
  output logic [31:0]   wbData,
  output logic          cyc,
  output logic          stb,
  output logic          we,
  output logic [31:0]   adr,
  output logic [31:0]   datMosi,
  input  logic [31:0]   datMiso,
  input  logic          ack,
  output logic          displayValid,
  output logic [31:0]   displayData
);

  logic memOp;
  logic busy;
  logic done;
  logic retire;

  assign memOp = memValid && (memCtrl.memRead || memCtrl.memWrite);
  assign done  = busy && ack;

  //////////////////////////////
  // Wishbone master
  //////////////////////////////
  // Bus cycle opens the cycle after a load or store arrives
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
    end else if (done) begin
      busy <= 1'b0;
    end else if (memOp) begin
      busy <= 1'b1;
    end
  end

  assign cyc     = busy;
  assign stb     = busy;
  assign we      = busy && memCtrl.memWrite;
  assign adr     = aluResult;
  assign datMosi = storeData;

  // Hold the pipeline until the slave acknowledges
  assign stall = memOp && !done;

  //////////////////////////////
  // Retirement
  //////////////////////////////
  assign retire = memValid && !stall;
  assign wbEn   = retire && memCtrl.regWrite;
  assign wbReg  = destReg;
  assign wbData = memCtrl.memToReg ? datMiso : aluResult;

  // DISP shows the forwarded rt value
  assign displayValid = retire && memCtrl.display;
  assign displayData  = storeData;

endmodule

`default_nettype wire

// ==== src/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic        Clk,
  input  logic        arstN,
  output logic [31:0] imemAddr,
  input  logic [31:0] imemData,
  output logic        wbCyc,
  output logic        wbStb,
  output logic        wbWe,
  output logic [31:0] wbAdr,
  output logic [31:0] wbDatMosi,
  input  logic [31:0] wbDatMiso,
  input  logic        wbAck,
  output logic        displayValid,
  output logic [31:0] displayData
);

  mipsPkg::instrU instrD;
  logic [31:0]    pcPlus4D;
  logic           validD;
  logic           stall;
  logic           redirect;
  logic [31:0]   redirectPc;
  logic           wbEn;
  logic [4:0]     wbReg;
  logic [31:0]    wbData;
  mipsPkg::ctrlS  memCtrl;
  logic [31:0]    aluResult;
  logic [31:0]    storeData;
  logic [4:0]     destReg;
  logic           memValid;

  decodeExecuteIf deD ();
  decodeExecuteIf deE ();

  fetchStage #(
    .resetPc(resetPc)
  ) u_fetch (
    .Clk(Clk),
    .arstN(arstN),
    .stall(stall),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .instrD(instrD),
    .pcPlus4D(pcPlus4D),
    .validD(validD)
  );

  decodeStage u_decode (
    .Clk(Clk),
    .arstN(arstN),
    .instrD(instrD),
    .pcPlus4D(pcPlus4D),
    .validD(validD),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .deOut(deD.source)
  );

  decodeExecuteReg u_deReg (
    .Clk(Clk),
    .arstN(arstN),
    .stall(stall),
    .redirect(redirect),
    .deIn(deD.sink),
    .deOut(deE.source)
  );

  executeStage u_execute (
    .Clk(Clk),
    .arstN(arstN),
    .stall(stall),
    .exIn(deE.sink),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .memCtrl(memCtrl),
    .aluResult(aluResult),
    .storeData(storeData),
    .destReg(destReg),
    .memValid(memValid)
  );

  memStage u_mem (
    .Clk(Clk),
    .arstN(arstN),
    .memCtrl(memCtrl),
    .aluResult(aluResult),
    .storeData(storeData),
    .destReg(destReg),
    .memValid(memValid),
    .stall(stall),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData),
    .cyc(wbCyc),
    .stb(wbStb),
    .we(wbWe),
    .adr(wbAdr),
    .datMosi(wbDatMosi),
    .datMiso(wbDatMiso),
    .ack(wbAck),
    .displayValid(displayValid),
    .displayData(displayData)
  );

endmodule

`default_nettype wire

// ==== src/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

  // Primary opcodes of the subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B,
    OP_DISP  = 6'h3F
  } opcodeE;

  // R-format function codes
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } functE;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } aluOpE;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JAL
  } branchTypeE;

  // One instruction word seen as R-format or I-format
  typedef union packed {
    struct packed {
      opcodeE     opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      functE      funct;
    } rType;
    struct packed {
      opcodeE      opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
    } iType;
  } instrU;

  typedef struct packed {
    logic       memRead;
    logic       memToReg;
    logic       memWrite;
    logic       aluSrc;
    logic       regWrite;
    logic       display;
    aluOpE      aluOp;
    branchTypeE branchType;
    logic       zeroExt;
  } ctrlS;

endpackage

`default_nettype wire

// ==== test/tbIsaModel.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// Program image ending in the halt branch
localparam int          progLen  = 160;
localparam logic [31:0] haltAddr = resetPc + 32'(4 * (progLen - 1));

logic [31:0] prog [progLen];
logic [31:0] expDisplay [$];
logic [31:0] expStoreAdr [$];
logic [31:0] expStoreDat [$];

// Initial data memory contents hashed from the full address
function automatic logic [31:0] memFill(input logic [31:0] addr);
  return (addr * 32'h9E37_79B9) ^ 32'hC3A5_5A3C;
endfunction

function automatic logic [31:0] encR(input mipsPkg::functE fn, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd,
                                     input logic [4:0] sh);
  return {mipsPkg::OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] encI(input mipsPkg::opcodeE op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// Few registers so that results get reused soon
function automatic logic [4:0] pickReg();
  if ($urandom_range(0, 8) == 0) return 5'd31;
  return 5'($urandom_range(0, 7));
endfunction

function automatic mipsPkg::functE pickFunct();
  case ($urandom_range(0, 7))
    0:       return mipsPkg::FN_ADDU;
    1:       return mipsPkg::FN_SUBU;
    2:       return mipsPkg::FN_AND;
    3:       return mipsPkg::FN_OR;
    4:       return mipsPkg::FN_XOR;
    5:       return mipsPkg::FN_SLT;
    6:       return mipsPkg::FN_SLL;
    default: return mipsPkg::FN_SRL;
  endcase
endfunction

//////////////////////////////
// Random program
//////////////////////////////
task automatic genProgram();
  int             maxSkip;
  logic [15:0]    off;
  mipsPkg::functE fn;
  for (int i = 0; i < progLen - 1; i++) begin
    // Forward targets only and never past the halt word
    maxSkip = progLen - 2 - i;
    if (maxSkip > 3) maxSkip = 3;
    off = 16'($urandom_range(0, maxSkip));
    case ($urandom_range(0, 20))
      0, 1, 2, 3, 4, 5: begin
        fn = pickFunct();
        if (fn == mipsPkg::FN_SLL || fn == mipsPkg::FN_SRL)
          prog[i] = encR(fn, 5'd0, pickReg(), pickReg(), 5'($urandom_range(0, 31)));
        else
          prog[i] = encR(fn, pickReg(), pickReg(), pickReg(), 5'd0);
      end
      6, 7:    prog[i] = encI(mipsPkg::OP_ADDIU, pickReg(), pickReg(), 16'($urandom));
      8:       prog[i] = encI(mipsPkg::OP_ANDI, pickReg(), pickReg(), 16'($urandom));
      9:       prog[i] = encI(mipsPkg::OP_ORI, pickReg(), pickReg(), 16'($urandom));
      10:      prog[i] = encI(mipsPkg::OP_LUI, 5'd0, pickReg(), 16'($urandom));
      11, 12:  prog[i] = encI(mipsPkg::OP_LW, 5'd0, pickReg(), 16'(4 * $urandom_range(0, 15)));
      13, 14:  prog[i] = encI(mipsPkg::OP_SW, 5'd0, pickReg(), 16'(4 * $urandom_range(0, 15)));
      15:      prog[i] = encI(mipsPkg::OP_BEQ, pickReg(), pickReg(), off);
      16:      prog[i] = encI(mipsPkg::OP_BNE, pickReg(), pickReg(), off);
      17:      prog[i] = encI(mipsPkg::OP_JAL, 5'd0, 5'd0, off);
      default: prog[i] = encI(mipsPkg::OP_DISP, 5'd0, pickReg(), 16'd0);
    endcase
  end
  // Branch to itself
  prog[progLen - 1] = encI(mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'hFFFF);
endtask

//////////////////////////////
// Architectural execution
//////////////////////////////
task automatic runModel();
  logic [31:0] regs [32];
  logic [31:0] modelMem [logic [31:0]];
  logic [31:0] pc;
  logic [31:0] nextPc;
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] simm;
  logic [31:0] res;
  logic [31:0] addr;
  logic [4:0]  dst;
  logic        wr;
  int          idx;
  for (int r = 0; r < 32; r++) regs[r] = 32'd0;
  pc = resetPc;
  while (pc != haltAddr) begin
    idx    = int'((pc - resetPc) >> 2);
    w      = prog[idx];
    a      = regs[w[25:21]];
    b      = regs[w[20:16]];
    simm   = {{16{w[15]}}, w[15:0]};
    addr   = a + simm;
    nextPc = pc + 32'd4;
    dst    = w[20:16];
    wr     = 1'b1;
    res    = 32'd0;
    case (w[31:26])
      mipsPkg::OP_RTYPE: begin
        dst = w[15:11];
        case (w[5:0])
          mipsPkg::FN_ADDU: res = a + b;
          mipsPkg::FN_SUBU: res = a - b;
          mipsPkg::FN_AND:  res = a & b;
          mipsPkg::FN_OR:   res = a | b;
          mipsPkg::FN_XOR:  res = a ^ b;
          mipsPkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mipsPkg::FN_SLL:  res = b << w[10:6];
          mipsPkg::FN_SRL:  res = b >> w[10:6];
          default:          wr = 1'b0;
        endcase
      end
      mipsPkg::OP_ADDIU: res = a + simm;
      mipsPkg::OP_ANDI:  res = a & {16'd0, w[15:0]};
      mipsPkg::OP_ORI:   res = a | {16'd0, w[15:0]};
      mipsPkg::OP_LUI:   res = {w[15:0], 16'd0};
      mipsPkg::OP_LW:    res = modelMem.exists(addr) ? modelMem[addr] : memFill(addr);
      mipsPkg::OP_SW: begin
        wr = 1'b0;
        modelMem[addr] = b;
        expStoreAdr.push_back(addr);
        expStoreDat.push_back(b);
      end
      mipsPkg::OP_BEQ: begin
        wr = 1'b0;
        if (a == b) nextPc = pc + 32'd4 + {simm[29:0], 2'b00};
      end
      mipsPkg::OP_BNE: begin
        wr = 1'b0;
        if (a != b) nextPc = pc + 32'd4 + {simm[29:0], 2'b00};
      end
      mipsPkg::OP_JAL: begin
        dst    = 5'd31;
        res    = pc + 32'd4;
        nextPc = pc + 32'd4 + {simm[29:0], 2'b00};
      end
      mipsPkg::OP_DISP: begin
        wr = 1'b0;
        expDisplay.push_back(b);
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) regs[dst] = res;
    pc = nextPc;
  end
endtask

`endif

// ==== test/tbCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbCore;

  localparam logic [31:0] resetPc = 32'h0000_0400;

  logic        Clk;
  logic        arstN;
  logic [31:0] imemAddr;
  logic [31:0] imemData;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [31:0] wbAdr;
  logic [31:0] wbDatMosi;
  logic [31:0] wbDatMiso;
  logic        wbAck;
  logic        displayValid;
  logic [31:0] displayData;

  logic [31:0] busMem [logic [31:0]];
  logic [31:0] romOffset;
  logic [1:0]  waitLeft;
  logic        pending;
  logic [31:0] heldAdr;

  `include "tbIsaModel.svh"

  // Eight cycles per instruction plus reset
  localparam int timeLimitNs = progLen * 8 * 8 + 10 * 8;

  mipsCore #(
    .resetPc(resetPc)
  ) u_dut (
    .Clk(Clk),
    .arstN(arstN),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatMosi(wbDatMosi),
    .wbDatMiso(wbDatMiso),
    .wbAck(wbAck),
    .displayValid(displayValid),
    .displayData(displayData)
  );

  initial begin
    Clk = 1'b0;
    forever #4 Clk = ~Clk;
  end

  // Combinational instruction ROM with nops outside the program
  assign romOffset = imemAddr - resetPc;
  assign imemData  = (imemAddr >= resetPc && romOffset < 32'(4 * progLen)) ?
                     prog[romOffset[9:2]] : 32'd0;

  //////////////////////////////
  // Checking helpers
  //////////////////////////////
  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      reportFailure($sformatf("mismatch at %0d ns: %s, got %08h, expected %08h",
                              $time, what, actual, expected));
    end
  endtask

  task automatic checkResetState();
    checkEq(32'(wbCyc), 32'd0, "wbCyc during reset");
    checkEq(32'(wbStb), 32'd0, "wbStb during reset");
    checkEq(32'(displayValid), 32'd0, "displayValid during reset");
    checkEq(imemAddr, resetPc, "imemAddr during reset");
  endtask

  function automatic logic [31:0] readBus(input logic [31:0] addr);
    return busMem.exists(addr) ? busMem[addr] : memFill(addr);
  endfunction

  task automatic serveTransfer();
    if (wbWe) begin
      if (expStoreAdr.size() == 0) begin
        reportFailure($sformatf("unexpected store to %08h after the last expected store",
                                wbAdr));
      end else begin
        checkEq(wbAdr, expStoreAdr.pop_front(), "store address");
        checkEq(wbDatMosi, expStoreDat.pop_front(), "store data");
        busMem[wbAdr] = wbDatMosi;
      end
    end else begin
      wbDatMiso <= readBus(wbAdr);
    end
  endtask

  //////////////////////////////
  // Wishbone slave memory
  //////////////////////////////
  // Zero to three wait states per transfer
  always @(posedge Clk) begin
    if (!arstN) begin
      wbAck    <= 1'b0;
      waitLeft <= 2'd0;
      pending  <= 1'b0;
    end else begin
      wbAck <= 1'b0;
      if (pending) begin
        checkEq(32'(wbCyc), 32'd1, "wbCyc dropped before ack");
        checkEq(32'(wbStb), 32'd1, "wbStb dropped before ack");
        checkEq(wbAdr, heldAdr, "wbAdr changed before ack");
      end
      if (wbCyc && wbStb && !wbAck) begin
        if (waitLeft == 2'd0) begin
          serveTransfer();
          wbAck    <= 1'b1;
          pending  <= 1'b0;
          waitLeft <= 2'($urandom_range(0, 3));
        end else begin
          waitLeft <= waitLeft - 2'd1;
          pending  <= 1'b1;
          heldAdr  <= wbAdr;
        end
      end
    end
  end

  // Display scoreboard
  always @(posedge Clk) begin
    if (arstN && displayValid) begin
      if (expDisplay.size() == 0) begin
        reportFailure("display pulse after the last expected display value");
      end else begin
        checkEq(displayData, expDisplay.pop_front(), "display value");
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    void'($urandom(32'h9593_6459));
    arstN     = 1'b1;
    wbAck     = 1'b0;
    wbDatMiso = 32'd0;
    waitLeft  = 2'd0;
    pending   = 1'b0;
    heldAdr   = 32'd0;
    genProgram();
    runModel();

    // Watchdog
    fork
      begin
        #(timeLimitNs);
        reportFailure("timeout, the program did not finish in time");
      end
    join_none

    @(posedge Clk);
    arstN <= 1'b0;
    repeat (10) begin
      @(posedge Clk);
      checkResetState();
    end
    arstN <= 1'b1;

    while (expDisplay.size() != 0 || expStoreAdr.size() != 0 || imemAddr != haltAddr) begin
      @(posedge Clk);
    end
    // Catch late extra displays or stores
    repeat (16) @(posedge Clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
